//--- bench/rob_properties.sv
////////////////////////////////////////
// handshake assertions bound into rob_subsystem
////////////////////////////////////////

`timescale 1ns/1ps

module rob_properties (
	input logic                     clock,
	input logic                     reset,
	input logic                     inst_valid,
	input logic                     inst_ready,
	input logic                     rob_tail_busy,
	input logic                     commit_valid,
	input logic                     commit_ready,
	input rob_types_pkg::arch_reg_t commit_arch_reg,
	input rob_types_pkg::phys_tag_t commit_tag,
	input rob_types_pkg::phys_tag_t commit_told,
	input logic                     commit_halt
);

	// an accepted instruction lands in a free ROB slot one cycle later
	accept_into_free_slot: assert property (@(posedge clock) disable iff (reset)
		inst_valid && inst_ready |=> !rob_tail_busy)
		else $error("instruction accepted while the ROB had no free slot");

	commit_hold: assert property (@(posedge clock) disable iff (reset)
		commit_valid && !commit_ready |=> commit_valid &&
			$stable({commit_arch_reg, commit_tag, commit_told, commit_halt}))
		else $error("commit output changed while stalled");

	commit_idle_after_reset: assert property (@(posedge clock)
		reset |=> !commit_valid)
		else $error("commit_valid high right after reset");

endmodule

bind rob_subsystem rob_properties i_properties (
	.clock           (clock),
	.reset           (reset),
	.inst_valid      (inst_valid),
	.inst_ready      (inst_ready),
	.rob_tail_busy   (i_rob.busy[i_rob.tail]),
	.commit_valid    (commit_valid),
	.commit_ready    (commit_ready),
	.commit_arch_reg (commit_arch_reg),
	.commit_tag      (commit_tag),
	.commit_told     (commit_told),
	.commit_halt     (commit_halt)
);

//--- bench/rob_tb.sv
////////////////////////////////////////
// testbench for the rename/ROB/commit core
// keeps its own map table and free list order to predict tag and told
////////////////////////////////////////

`timescale 1ns/1ps

module rob_tb;

	import rob_config_pkg::*;
	import rob_types_pkg::*;

	localparam int ROB_DEPTH    = DEFAULT_ROB_DEPTH;
	localparam int COMMIT_DEPTH = DEFAULT_COMMIT_DEPTH;
	localparam int FREE_DEPTH   = NUM_PHYS - NUM_ARCH;
	localparam int WAIT_LIMIT   = 200;  // cycles per wait

	logic      clock;
	logic      reset;
	logic      inst_valid;
	logic      inst_ready;
	arch_reg_t inst_arch_reg;
	logic      inst_halt;
	logic      cdb_valid;
	phys_tag_t cdb_tag;
	logic      commit_valid;
	logic      commit_ready;
	arch_reg_t commit_arch_reg;
	phys_tag_t commit_tag;
	phys_tag_t commit_told;
	logic      commit_halt;

	////////////////////////////////////////
	// reference model state
	////////////////////////////////////////

	phys_tag_t  model_map [NUM_ARCH];
	phys_tag_t  model_free [$];   // oldest free tag at the front
	rob_entry_t expected [$];     // program order
	phys_tag_t  issued [$];       // tags still to complete
	int         alloc_count;

	int     checks;
	int     errors;
	integer seed;

	rob_subsystem #(
		.ROB_DEPTH    (ROB_DEPTH),
		.COMMIT_DEPTH (COMMIT_DEPTH)
	) i_dut (
		.clock           (clock),
		.reset           (reset),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.inst_arch_reg   (inst_arch_reg),
		.inst_halt       (inst_halt),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.commit_valid    (commit_valid),
		.commit_ready    (commit_ready),
		.commit_arch_reg (commit_arch_reg),
		.commit_tag      (commit_tag),
		.commit_told     (commit_told),
		.commit_halt     (commit_halt)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// identity map with tags 32..127 free in order
	task automatic reset_model();
		model_free.delete();
		expected.delete();
		issued.delete();
		for (int r = 0; r < NUM_ARCH; r++)
			model_map[r] = phys_tag_t'(r);
		for (int t = NUM_ARCH; t < NUM_PHYS; t++)
			model_free.push_back(phys_tag_t'(t));
		alloc_count = 0;
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at time %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// fields shown as reg/tag/told/halt
	task automatic compare_entry(string name, rob_entry_t got, rob_entry_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at time %0t: %s got %0d/%0d/%0d/%b expected %0d/%0d/%0d/%b",
				$time, name, got.arch_reg, got.tag, got.told, got.halt,
				exp.arch_reg, exp.tag, exp.told, exp.halt);
		end
	endtask

	task automatic report_test(string name, int errors_before);
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	////////////////////////////////////////
	// drivers and monitors
	////////////////////////////////////////

	task automatic dispatch_inst(arch_reg_t r, logic h);
		int         waited;
		rob_entry_t e;
		waited = 0;
		@(posedge clock);
		inst_valid    <= 1'b1;
		inst_arch_reg <= r;
		inst_halt     <= h;
		@(negedge clock);
		while (!inst_ready && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (!inst_ready)
		begin
			errors++;
			$display("timeout: inst_ready stayed low, r%0d never accepted", r);
		end
		else
		begin
			e.arch_reg = r;
			e.tag      = model_free.pop_front();
			e.told     = model_map[r];   // mapping before this instruction
			e.halt     = h;
			model_map[r] = e.tag;
			expected.push_back(e);
			issued.push_back(e.tag);
			alloc_count++;
		end
		@(posedge clock);  // accept edge
		inst_valid <= 1'b0;
	endtask

	task automatic complete_tag(phys_tag_t t);
		@(posedge clock);
		cdb_valid <= 1'b1;
		cdb_tag   <= t;
		@(posedge clock);
		cdb_valid <= 1'b0;
	endtask

	// raises commit_ready for exactly one handshake
	task automatic collect_commit();
		int         waited;
		rob_entry_t got;
		rob_entry_t exp;
		waited = 0;
		@(posedge clock);
		commit_ready <= 1'b1;
		@(negedge clock);
		while (!commit_valid && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (!commit_valid)
		begin
			errors++;
			$display("timeout: no commit arrived while %0d were outstanding", expected.size());
		end
		else if (expected.size() == 0)
		begin
			errors++;
			$display("commit of tag %0d arrived with nothing outstanding", commit_tag);
		end
		else
		begin
			got.arch_reg = commit_arch_reg;
			got.tag      = commit_tag;
			got.told     = commit_told;
			got.halt     = commit_halt;
			exp = expected.pop_front();
			compare_entry("commit", got, exp);
			model_free.push_back(exp.told);  // told rejoins the free list
		end
		@(posedge clock);  // handshake edge
		commit_ready <= 1'b0;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic reset_state_check();
		int start;
		start = errors;
		@(negedge clock);
		compare_bit("inst_ready", inst_ready, 1'b1);
		compare_bit("commit_valid", commit_valid, 1'b0);
		report_test("reset state", start);
	endtask

	task automatic reverse_completion_order();
		int start;
		start = errors;
		dispatch_inst(5'd3, 1'b0);
		dispatch_inst(5'd7, 1'b0);
		dispatch_inst(5'd3, 1'b0);   // told is the tag from two back
		dispatch_inst(5'd12, 1'b0);
		for (int i = 3; i >= 0; i--)
			complete_tag(issued[i]);
		repeat (4) collect_commit();
		issued.delete();
		report_test("reverse completion", start);
	endtask

	// commit_ready idles low outside collect_commit
	task automatic fill_under_backpressure();
		int start;
		start = errors;
		for (int i = 0; i < ROB_DEPTH; i++)
			dispatch_inst(arch_reg_t'(i + 1), 1'b0);
		@(negedge clock);
		compare_bit("inst_ready", inst_ready, 1'b0);  // ROB full
		for (int i = 0; i < ROB_DEPTH; i++)
			complete_tag(issued[i]);
		repeat (ROB_DEPTH) collect_commit();
		issued.delete();
		report_test("back-pressure", start);
	endtask

	task automatic halt_flag_passthrough();
		int start;
		start = errors;
		dispatch_inst(5'd4, 1'b0);
		dispatch_inst(5'd9, 1'b1);
		dispatch_inst(5'd4, 1'b0);
		foreach (issued[k])
			complete_tag(issued[k]);
		repeat (3) collect_commit();
		issued.delete();
		report_test("halt flag", start);
	endtask

	task automatic random_completion_order();
		int        start;
		int        j;
		phys_tag_t t;
		start = errors;
		for (int b = 0; b < 2; b++)  // two batches of ten
		begin
			for (int i = 0; i < 10; i++)
				dispatch_inst(arch_reg_t'($random(seed)), 1'b0);
			for (int i = issued.size() - 1; i > 0; i--)
			begin
				j = $unsigned($random(seed)) % (i + 1);
				t = issued[i];
				issued[i] = issued[j];
				issued[j] = t;
			end
			foreach (issued[k])
				complete_tag(issued[k]);
			repeat (10) collect_commit();
			issued.delete();
		end
		report_test("random completion", start);
	endtask

	// runs well past the first 96 allocations
	task automatic freed_tag_reuse();
		int start;
		start = errors;
		repeat (12)
		begin
			for (int i = 0; i < 8; i++)
				dispatch_inst(arch_reg_t'(i * 3), 1'b0);
			foreach (issued[k])
				complete_tag(issued[k]);
			repeat (8) collect_commit();
			issued.delete();
		end
		if (alloc_count <= FREE_DEPTH)
		begin
			errors++;
			$display("only %0d tags allocated, reuse of freed tags never reached", alloc_count);
		end
		report_test("tag reuse", start);
	endtask

	initial
	begin
		seed   = 32'h01e4c714;
		checks = 0;
		errors = 0;
		reset         <= 1'b1;
		inst_valid    <= 1'b0;
		inst_arch_reg <= '0;
		inst_halt     <= 1'b0;
		cdb_valid     <= 1'b0;
		cdb_tag       <= '0;
		commit_ready  <= 1'b0;
		reset_model();
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		reset_state_check();
		reverse_completion_order();
		fill_under_backpressure();
		halt_flag_passthrough();
		random_completion_order();
		freed_tag_reuse();

		repeat (4) @(posedge clock);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- flist.f
src/rob_config_pkg.sv
src/rob_types_pkg.sv
src/dispatch_if.sv
src/retire_if.sv
src/rename_dispatch.sv
src/reorder_buffer.sv
src/commit_stage.sv
src/rob_subsystem.sv
bench/rob_properties.sv
bench/rob_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rob_tb -f flist.f

status=0
output=$(./obj_dir/Vrob_tb) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -q "TEST PASSED"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

//--- src/commit_stage.sv
////////////////////////////////////////
// commit queue behind the ROB
// valid/ready output, returns told tags to the free list
////////////////////////////////////////

`timescale 1ns/1ps

module commit_stage #(
	parameter int COMMIT_DEPTH = 2
) (
	input  logic                      clock,
	input  logic                      reset,
	retire_if.sink                    retire,
	output logic                      commit_valid,
	input  logic                      commit_ready,
	output rob_types_pkg::rob_entry_t commit_entry,
	output logic                      free_valid,
	output rob_types_pkg::phys_tag_t  free_tag
);

	import rob_types_pkg::*;

	localparam int PTR_BITS = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(COMMIT_DEPTH + 1);

	rob_entry_t          queue [COMMIT_DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	logic                pop;

	function automatic logic [PTR_BITS-1:0] wrap_inc(logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(COMMIT_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign commit_valid = (count != '0);
	assign commit_entry = queue[rd_ptr];   // oldest entry, steady until popped
	assign pop          = commit_valid && commit_ready;
	assign free_valid   = pop;
	assign free_tag     = commit_entry.told;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rd_ptr        <= '0;
			wr_ptr        <= '0;
			count         <= '0;
			retire.credit <= 1'b0;
		end
		else
		begin
			if (retire.valid)
				wr_ptr <= wrap_inc(wr_ptr);
			if (pop)
				rd_ptr <= wrap_inc(rd_ptr);
			case ({retire.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			retire.credit <= pop;
		end
	end

	always_ff @(posedge clock)
	begin
		if (retire.valid)
		begin
			queue[wr_ptr].arch_reg <= retire.arch_reg;
			queue[wr_ptr].tag      <= retire.tag;
			queue[wr_ptr].told     <= retire.told;
			queue[wr_ptr].halt     <= retire.halt;
		end
	end

endmodule

//--- src/dispatch_if.sv
////////////////////////////////////////
// rename to ROB link, one entry per valid pulse
// credit pulses back once per freed ROB slot
////////////////////////////////////////

`timescale 1ns/1ps

interface dispatch_if ();

	import rob_types_pkg::*;

	logic      valid;
	arch_reg_t arch_reg;
	phys_tag_t tag;
	phys_tag_t told;
	logic      halt;
	logic      credit;

	modport producer (output valid, arch_reg, tag, told, halt, input credit);
	modport buffer   (input valid, arch_reg, tag, told, halt, output credit);

endinterface

//--- src/rename_dispatch.sv
////////////////////////////////////////
// rename front end: free list, map table, dispatch credits
// accepts one instruction per cycle, registers it onto dispatch_if
////////////////////////////////////////

`timescale 1ns/1ps

module rename_dispatch #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      inst_valid,
	input  rob_types_pkg::arch_reg_t  inst_arch_reg,
	input  logic                      inst_halt,
	output logic                      inst_ready,
	input  logic                      free_valid,
	input  rob_types_pkg::phys_tag_t  free_tag,
	dispatch_if.producer              dispatch
);

	import rob_config_pkg::*;
	import rob_types_pkg::*;

	localparam int FREE_DEPTH  = NUM_PHYS - NUM_ARCH;
	localparam int CREDIT_BITS = $clog2(ROB_DEPTH + 1);

	phys_tag_t free_tags [FREE_DEPTH];
	free_ptr_t free_head;  // oldest free tag
	free_ptr_t free_tail;  // next slot for a returned tag
	free_cnt_t free_count;

	phys_tag_t map_table [NUM_ARCH];

	logic [CREDIT_BITS-1:0] credits;
	logic                   accept;

	function automatic free_ptr_t wrap_inc(free_ptr_t ptr);
		return (ptr == free_ptr_t'(FREE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign inst_ready = (credits != '0) && (free_count != '0);
	assign accept     = inst_valid && inst_ready;

	////////////////////////////////////////
	// free list and map table
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < FREE_DEPTH; i++)
				free_tags[i] <= phys_tag_t'(NUM_ARCH + i);  // 32..127 in order
			for (int r = 0; r < NUM_ARCH; r++)
				map_table[r] <= phys_tag_t'(r);             // identity mapping
			free_head  <= '0;
			free_tail  <= '0;
			free_count <= free_cnt_t'(FREE_DEPTH);
		end
		else
		begin
			if (accept)
			begin
				map_table[inst_arch_reg] <= free_tags[free_head];
				free_head <= wrap_inc(free_head);
			end
			if (free_valid)
			begin
				free_tags[free_tail] <= free_tag;
				free_tail <= wrap_inc(free_tail);
			end
			case ({accept, free_valid})
				2'b10:   free_count <= free_count - 1'b1;
				2'b01:   free_count <= free_count + 1'b1;
				default: free_count <= free_count;
			endcase
		end
	end

	// ROB slot credits
	always_ff @(posedge clock)
	begin
		if (reset)
			credits <= CREDIT_BITS'(ROB_DEPTH);
		else
		begin
			case ({accept, dispatch.credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////
	// dispatch register
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			dispatch.valid <= 1'b0;
		else
			dispatch.valid <= accept;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			dispatch.arch_reg <= inst_arch_reg;
			dispatch.tag      <= free_tags[free_head];
			dispatch.told     <= map_table[inst_arch_reg];  // mapping before update
			dispatch.halt     <= inst_halt;
		end
	end

endmodule

//--- src/reorder_buffer.sv
////////////////////////////////////////
// reorder buffer, program order entry store
// marks entries done from the CDB, retires the head in order
////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer #(
	parameter int ROB_DEPTH    = 16,
	parameter int COMMIT_DEPTH = 2
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     cdb_valid,
	input  rob_types_pkg::phys_tag_t cdb_tag,
	dispatch_if.buffer               dispatch,
	retire_if.source                 retire
);

	import rob_types_pkg::*;

	localparam int PTR_BITS    = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
	localparam int CREDIT_BITS = $clog2(COMMIT_DEPTH + 1);

	rob_entry_t entries [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] busy;
	logic [ROB_DEPTH-1:0] done;
	logic [PTR_BITS-1:0]  head;
	logic [PTR_BITS-1:0]  tail;

	logic [CREDIT_BITS-1:0] commit_credits;

	rob_entry_t           incoming;
	rob_entry_t           head_entry;
	logic [ROB_DEPTH-1:0] cdb_hit;
	logic                 arrive_hit;
	logic                 retire_now;

	function automatic logic [PTR_BITS-1:0] wrap_inc(logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb
	begin
		incoming.arch_reg = dispatch.arch_reg;
		incoming.tag      = dispatch.tag;
		incoming.told     = dispatch.told;
		incoming.halt     = dispatch.halt;
	end

	assign head_entry = entries[head];
	assign arrive_hit = cdb_valid && (dispatch.tag == cdb_tag);  // same-cycle completion
	assign retire_now = busy[head] && done[head] && (commit_credits != '0);

	// tag match against every live entry
	always_comb
	begin
		for (int i = 0; i < ROB_DEPTH; i++)
			cdb_hit[i] = cdb_valid && busy[i] && (entries[i].tag == cdb_tag);
	end

	////////////////////////////////////////
	// control state
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy            <= '0;
			done            <= '0;
			head            <= '0;
			tail            <= '0;
			commit_credits  <= CREDIT_BITS'(COMMIT_DEPTH);
			retire.valid    <= 1'b0;
			dispatch.credit <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < ROB_DEPTH; i++)
				if (cdb_hit[i])
					done[i] <= 1'b1;
			if (retire_now)
			begin
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head       <= wrap_inc(head);
			end
			if (dispatch.valid)  // slot is free, credits guarantee it
			begin
				busy[tail] <= 1'b1;
				done[tail] <= arrive_hit;
				tail       <= wrap_inc(tail);
			end
			case ({retire_now, retire.credit})
				2'b10:   commit_credits <= commit_credits - 1'b1;
				2'b01:   commit_credits <= commit_credits + 1'b1;
				default: commit_credits <= commit_credits;
			endcase
			retire.valid    <= retire_now;
			dispatch.credit <= retire_now;  // freed slot back to rename
		end
	end

	// payload, no reset
	always_ff @(posedge clock)
	begin
		if (dispatch.valid)
			entries[tail] <= incoming;
		if (retire_now)
		begin
			retire.arch_reg <= head_entry.arch_reg;
			retire.tag      <= head_entry.tag;
			retire.told     <= head_entry.told;
			retire.halt     <= head_entry.halt;
		end
	end

endmodule

//--- src/retire_if.sv
////////////////////////////////////////
// ROB to commit stage link for retired entries
// credit pulses back when the commit queue pops
////////////////////////////////////////

`timescale 1ns/1ps

interface retire_if ();

	import rob_types_pkg::*;

	logic      valid;
	arch_reg_t arch_reg;
	phys_tag_t tag;
	phys_tag_t told;
	logic      halt;
	logic      credit;

	modport source (output valid, arch_reg, tag, told, halt, input credit);
	modport sink   (input valid, arch_reg, tag, told, halt, output credit);

endinterface

//--- src/rob_config_pkg.sv
////////////////////////////////////////
// size constants for the rename back end
// imported by the type package, the top level and the bench
////////////////////////////////////////

package rob_config_pkg;

	// architectural register file
	localparam int ARCH_REG_BITS = 5;
	localparam int NUM_ARCH      = 32;

	// physical register file, tags 0..127
	localparam int PHYS_TAG_BITS = 7;
	localparam int NUM_PHYS      = 128;

	// top level defaults, overridable per instance
	localparam int DEFAULT_ROB_DEPTH    = 16;
	localparam int DEFAULT_COMMIT_DEPTH = 2;

endpackage

//--- src/rob_subsystem.sv
////////////////////////////////////////
// top level of the retirement core
// rename -> ROB -> commit, plain ports for the bench
////////////////////////////////////////

`timescale 1ns/1ps

module rob_subsystem #(
	parameter int ROB_DEPTH    = rob_config_pkg::DEFAULT_ROB_DEPTH,
	parameter int COMMIT_DEPTH = rob_config_pkg::DEFAULT_COMMIT_DEPTH
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     inst_valid,
	output logic                     inst_ready,
	input  rob_types_pkg::arch_reg_t inst_arch_reg,
	input  logic                     inst_halt,
	input  logic                     cdb_valid,
	input  rob_types_pkg::phys_tag_t cdb_tag,
	output logic                     commit_valid,
	input  logic                     commit_ready,
	output rob_types_pkg::arch_reg_t commit_arch_reg,
	output rob_types_pkg::phys_tag_t commit_tag,
	output rob_types_pkg::phys_tag_t commit_told,
	output logic                     commit_halt
);

	import rob_types_pkg::*;

	rob_entry_t commit_entry;
	logic       free_valid;
	phys_tag_t  free_tag;

	dispatch_if dispatch_link ();
	retire_if   retire_link ();

	rename_dispatch #(
		.ROB_DEPTH (ROB_DEPTH)
	) i_rename (
		.clock         (clock),
		.reset         (reset),
		.inst_valid    (inst_valid),
		.inst_arch_reg (inst_arch_reg),
		.inst_halt     (inst_halt),
		.inst_ready    (inst_ready),
		.free_valid    (free_valid),
		.free_tag      (free_tag),
		.dispatch      (dispatch_link.producer)
	);

	reorder_buffer #(
		.ROB_DEPTH    (ROB_DEPTH),
		.COMMIT_DEPTH (COMMIT_DEPTH)
	) i_rob (
		.clock     (clock),
		.reset     (reset),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.dispatch  (dispatch_link.buffer),
		.retire    (retire_link.source)
	);

	commit_stage #(
		.COMMIT_DEPTH (COMMIT_DEPTH)
	) i_commit (
		.clock        (clock),
		.reset        (reset),
		.retire       (retire_link.sink),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready),
		.commit_entry (commit_entry),
		.free_valid   (free_valid),
		.free_tag     (free_tag)
	);

	// commit output fields
	assign commit_arch_reg = commit_entry.arch_reg;
	assign commit_tag      = commit_entry.tag;
	assign commit_told     = commit_entry.told;
	assign commit_halt     = commit_entry.halt;

endmodule

//--- src/rob_types_pkg.sv
////////////////////////////////////////
// shared data types for rename, ROB and commit
// modules import this inside their body
////////////////////////////////////////

package rob_types_pkg;

	import rob_config_pkg::*;

	typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;
	typedef logic [PHYS_TAG_BITS-1:0] phys_tag_t;

	// free list bookkeeping, holds up to NUM_PHYS - NUM_ARCH tags
	typedef logic [PHYS_TAG_BITS-1:0] free_ptr_t;
	typedef logic [PHYS_TAG_BITS:0]   free_cnt_t;

	// one in-flight instruction, 20 bits
	typedef struct packed {
		arch_reg_t arch_reg;
		phys_tag_t tag;   // newly allocated
		phys_tag_t told;  // previous mapping, freed at commit
		logic      halt;
	} rob_entry_t;

endpackage
